// ==== sources.f ====
+incdir+tb
design/axi_mem_pkg.sv
design/axi_lite_if.sv
design/axi_sram.sv
design/axi_rr_arbiter.sv
design/axi_mem_top.sv
tb/tb_axi_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and take the status from the testbench output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_axi_mem -f sources.f -Mdir obj_dir &&
./obj_dir/Vtb_axi_mem | tee /dev/stderr | grep -qx "No errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb/tb_axi_tasks.svh ====
// wrong value, logged and counted
task automatic report_err(input string sig, input logic [63:0] want, input logic [63:0] got);
	$display("ERR %0t %s expected %h got %h", $time, sig, want, got);
	errors++;
endtask

// strobe rule, byte i taken from data where strb[i] is set
function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
		input logic [7:0] strb);
	logic [63:0] res;
	res = old;
	for (int i = 0; i < 8; i++) begin
		if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
	end
	return res;
endfunction

// word index past the array means slverr
function automatic logic [1:0] expected_resp(input logic [31:0] addr);
	return (32'(addr >> 3) < 32'(mem_words)) ? resp_okay : resp_slverr;
endfunction

// one read on master m, rready held low for stall cycles after rvalid
task automatic read_word(input int m, input logic [31:0] addr, input int stall,
		output logic [63:0] data, output logic [1:0] resp);
	logic [63:0] first;
	@(posedge clk);
	arvalid[m] <= 1'b1;
	araddr[m] <= addr;
	@(negedge clk);
	while (!arready[m]) @(negedge clk);
	@(posedge clk);
	arvalid[m] <= 1'b0;
	// response due one cycle after the ar transfer
	@(negedge clk);
	if (rvalid[m] !== 1'b1) report_err($sformatf("m%0d_rvalid", m), 64'd1, 64'(rvalid[m]));
	while (!rvalid[m]) @(negedge clk);
	first = rdata[m];
	repeat (stall) begin
		@(negedge clk);
		if (rvalid[m] !== 1'b1) report_err($sformatf("m%0d_rvalid", m), 64'd1, 64'(rvalid[m]));
		if (rdata[m] !== first) report_err($sformatf("m%0d_rdata", m), first, rdata[m]);
	end
	@(posedge clk);
	rready[m] <= 1'b1;
	@(negedge clk);
	data = rdata[m];
	resp = rresp[m];
	@(posedge clk);
	rready[m] <= 1'b0;
endtask

// one write on master m, bready held low for stall cycles after bvalid
task automatic write_word(input int m, input logic [31:0] addr, input logic [63:0] data,
		input logic [7:0] strb, input int stall, output logic [1:0] resp);
	@(posedge clk);
	awvalid[m] <= 1'b1;
	awaddr[m] <= addr;
	wdata[m] <= data;
	wstrb[m] <= strb;
	@(negedge clk);
	while (!(awready[m] && wready[m])) @(negedge clk);
	@(posedge clk);
	awvalid[m] <= 1'b0;
	@(negedge clk);
	if (bvalid[m] !== 1'b1) report_err($sformatf("m%0d_bvalid", m), 64'd1, 64'(bvalid[m]));
	while (!bvalid[m]) @(negedge clk);
	repeat (stall) begin
		@(negedge clk);
		if (bvalid[m] !== 1'b1) report_err($sformatf("m%0d_bvalid", m), 64'd1, 64'(bvalid[m]));
	end
	@(posedge clk);
	bready[m] <= 1'b1;
	@(negedge clk);
	resp = bresp[m];
	@(posedge clk);
	bready[m] <= 1'b0;
endtask

// write, check bresp, then fold into the model
task automatic write_check(input int m, input logic [31:0] addr, input logic [63:0] data,
		input logic [7:0] strb, input int stall);
	logic [1:0] resp;
	logic [63:0] old;
	write_word(m, addr, data, strb, stall, resp);
	if (resp !== expected_resp(addr))
		report_err($sformatf("m%0d_bresp", m), 64'(expected_resp(addr)), 64'(resp));
	if (expected_resp(addr) == resp_okay) begin
		old = model.exists(int'(addr >> 3)) ? model[int'(addr >> 3)] : '0;
		model[int'(addr >> 3)] = merge_bytes(old, data, strb);
	end
endtask

// read, compare against the model, zero for slverr
task automatic read_check(input int m, input logic [31:0] addr, input int stall);
	logic [63:0] data;
	logic [1:0] resp;
	logic [63:0] want;
	read_word(m, addr, stall, data, resp);
	want = (expected_resp(addr) == resp_okay) ? model[int'(addr >> 3)] : '0;
	if (resp !== expected_resp(addr))
		report_err($sformatf("m%0d_rresp", m), 64'(expected_resp(addr)), 64'(resp));
	if (data !== want) report_err($sformatf("m%0d_rdata", m), want, data);
endtask

// nothing granted yet, so every ready and valid is low
task automatic idle_after_reset();
	@(negedge clk);
	if (rvalid !== 2'b00) report_err("rvalid", 64'd0, 64'(rvalid));
	if (bvalid !== 2'b00) report_err("bvalid", 64'd0, 64'(bvalid));
	if (arready !== 2'b00) report_err("arready", 64'd0, 64'(arready));
	if (awready !== 2'b00) report_err("awready", 64'd0, 64'(awready));
	if (wready !== 2'b00) report_err("wready", 64'd0, 64'(wready));
endtask

// m0 writes, m1 reads back; word 0 included for the slverr test
task automatic full_strobe_writes();
	for (int i = 0; i < 8; i++) begin
		write_check(0, 32'(i * 40), {$random(seed), $random(seed)}, 8'hff, 0);
	end
	for (int i = 0; i < 8; i++) begin
		read_check(1, 32'(i * 40), 0);
	end
endtask

task automatic partial_strobes();
	write_check(1, 32'h100, 64'h0123_4567_89ab_cdef, 8'hff, 0);
	write_check(0, 32'h100, {$random(seed), $random(seed)}, 8'b1010_0110, 0);
	read_check(1, 32'h100, 0);
	// random mask on top of the merged word
	write_check(1, 32'h100, {$random(seed), $random(seed)}, 8'($random(seed)), 0);
	read_check(0, 32'h100, 0);
endtask

task automatic out_of_range();
	write_check(0, 32'(mem_words * 8), {$random(seed), $random(seed)}, 8'hff, 0);
	read_check(1, 32'(mem_words * 8), 0);
	write_check(1, 32'hffff_fff8, {$random(seed), $random(seed)}, 8'hff, 0);
	read_check(0, 32'hffff_fff8, 0);
	// index aliasing onto word 0 would show here
	read_check(0, 32'h0, 0);
endtask

task automatic concurrent_access();
	int rises [2];
	logic [1:0] prev;
	logic [1:0] done;
	rises[0] = 0;
	rises[1] = 0;
	prev = 2'b00;
	done = 2'b00;
	fork
		begin
			read_check(0, 32'h28, 0);
			done[0] = 1'b1;
		end
		begin
			read_check(1, 32'h50, 0);
			done[1] = 1'b1;
		end
		// rvalid rising edges per master until both reads are back
		begin
			while (done != 2'b11) begin
				@(negedge clk);
				for (int m = 0; m < 2; m++) begin
					if (rvalid[m] && !prev[m]) rises[m]++;
				end
				prev = rvalid;
			end
		end
	join
	// one beat each, none routed to the other master
	for (int m = 0; m < 2; m++) begin
		if (rises[m] != 1)
			report_err($sformatf("m%0d_rvalid beats", m), 64'd1, 64'(rises[m]));
	end
	// no second beat for either master
	@(negedge clk);
	if (rvalid !== 2'b00) report_err("rvalid", 64'd0, 64'(rvalid));
	fork
		write_check(0, 32'h200, {$random(seed), $random(seed)}, 8'hff, 0);
		write_check(1, 32'h208, {$random(seed), $random(seed)}, 8'hff, 0);
	join
	read_check(0, 32'h208, 0);
	read_check(1, 32'h200, 0);
endtask

task automatic back_pressure();
	int stall;
	time t_rd;
	time t_wr;
	write_check(0, 32'h300, {$random(seed), $random(seed)}, 8'hff, 0);
	// m1 read held, m0 write goes through
	stall = 1 + int'({$random(seed)} % 32'd8);
	fork
		begin
			read_check(1, 32'h300, stall);
			t_rd = $time;
		end
		begin
			write_check(0, 32'h308, {$random(seed), $random(seed)}, 8'hff, 0);
			t_wr = $time;
		end
	join
	if (t_wr >= t_rd) begin
		$display("m0 write did not finish while the m1 read response was held");
		errors++;
	end
	// m1 write response held, m0 read goes through
	stall = 1 + int'({$random(seed)} % 32'd8);
	fork
		begin
			write_check(1, 32'h310, {$random(seed), $random(seed)}, 8'hff, stall);
			t_wr = $time;
		end
		begin
			read_check(0, 32'h308, 0);
			t_rd = $time;
		end
	join
	if (t_rd >= t_wr) begin
		$display("m0 read did not finish while the m1 write response was held");
		errors++;
	end
	read_check(0, 32'h310, 0);
endtask

// ==== tb/tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem;
	import axi_mem_pkg::*;

	localparam int mem_words = 1024;
	// tests x transactions x cycles x period, in ns
	localparam int limit_ns = 6 * 40 * 50 * 20;

	logic                   clk;
	logic                   rst;

	// bit or row 0 is m0, 1 is m1
	logic [1:0]             arvalid;
	logic [1:0][addr_w-1:0] araddr;
	logic [1:0]             arready;
	logic [1:0]             rvalid;
	logic [1:0][data_w-1:0] rdata;
	logic [1:0][1:0]        rresp;
	logic [1:0]             rready;
	// aw and w always presented together, one valid feeds both
	logic [1:0]             awvalid;
	logic [1:0][addr_w-1:0] awaddr;
	logic [1:0]             awready;
	logic [1:0][data_w-1:0] wdata;
	logic [1:0][strb_w-1:0] wstrb;
	logic [1:0]             wready;
	logic [1:0]             bvalid;
	logic [1:0][1:0]        bresp;
	logic [1:0]             bready;

	int                     errors;
	int                     seed;
	// expected word per written index
	logic [data_w-1:0]      model [int];

	axi_mem_top #(
		.mem_words (mem_words)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.m0_arvalid (arvalid[0]), .m1_arvalid (arvalid[1]),
		.m0_araddr  (araddr[0]),  .m1_araddr  (araddr[1]),
		.m0_arready (arready[0]), .m1_arready (arready[1]),
		.m0_rvalid  (rvalid[0]),  .m1_rvalid  (rvalid[1]),
		.m0_rdata   (rdata[0]),   .m1_rdata   (rdata[1]),
		.m0_rresp   (rresp[0]),   .m1_rresp   (rresp[1]),
		.m0_rready  (rready[0]),  .m1_rready  (rready[1]),
		.m0_awvalid (awvalid[0]), .m1_awvalid (awvalid[1]),
		.m0_awaddr  (awaddr[0]),  .m1_awaddr  (awaddr[1]),
		.m0_awready (awready[0]), .m1_awready (awready[1]),
		.m0_wvalid  (awvalid[0]), .m1_wvalid  (awvalid[1]),
		.m0_wdata   (wdata[0]),   .m1_wdata   (wdata[1]),
		.m0_wstrb   (wstrb[0]),   .m1_wstrb   (wstrb[1]),
		.m0_wready  (wready[0]),  .m1_wready  (wready[1]),
		.m0_bvalid  (bvalid[0]),  .m1_bvalid  (bvalid[1]),
		.m0_bresp   (bresp[0]),   .m1_bresp   (bresp[1]),
		.m0_bready  (bready[0]),  .m1_bready  (bready[1])
	);

	`include "tb_axi_tasks.svh"

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ends a hung run
	initial begin
		#(limit_ns);
		$display("timeout at %0t, a handshake never completed", $time);
		$display("Errors found");
		$finish;
	end

	initial begin
		seed = 65;
		errors = 0;
		rst <= 1'b1;
		arvalid <= '0;
		araddr <= '0;
		rready <= '0;
		awvalid <= '0;
		awaddr <= '0;
		wdata <= '0;
		wstrb <= '0;
		bready <= '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		idle_after_reset();
		full_strobe_writes();
		partial_strobes();
		out_of_range();
		concurrent_access();
		back_pressure();

		repeat (2) @(posedge clk);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== design/axi_mem_top.sv ====
`timescale 1ns/1ps

module axi_mem_top #(
	parameter int mem_words = 1024
) (
	input  logic                            clk,
	input  logic                            rst,

	// m0, instruction fetch
	input  logic                            m0_arvalid,
	input  logic [axi_mem_pkg::addr_w-1:0]  m0_araddr,
	output logic                            m0_arready,
	output logic                            m0_rvalid,
	output logic [axi_mem_pkg::data_w-1:0]  m0_rdata,
	output axi_mem_pkg::resp_t              m0_rresp,
	input  logic                            m0_rready,
	input  logic                            m0_awvalid,
	input  logic [axi_mem_pkg::addr_w-1:0]  m0_awaddr,
	output logic                            m0_awready,
	input  logic                            m0_wvalid,
	input  logic [axi_mem_pkg::data_w-1:0]  m0_wdata,
	input  logic [axi_mem_pkg::strb_w-1:0]  m0_wstrb,
	output logic                            m0_wready,
	output logic                            m0_bvalid,
	output axi_mem_pkg::resp_t              m0_bresp,
	input  logic                            m0_bready,

	// m1, load/store
	input  logic                            m1_arvalid,
	input  logic [axi_mem_pkg::addr_w-1:0]  m1_araddr,
	output logic                            m1_arready,
	output logic                            m1_rvalid,
	output logic [axi_mem_pkg::data_w-1:0]  m1_rdata,
	output axi_mem_pkg::resp_t              m1_rresp,
	input  logic                            m1_rready,
	input  logic                            m1_awvalid,
	input  logic [axi_mem_pkg::addr_w-1:0]  m1_awaddr,
	output logic                            m1_awready,
	input  logic                            m1_wvalid,
	input  logic [axi_mem_pkg::data_w-1:0]  m1_wdata,
	input  logic [axi_mem_pkg::strb_w-1:0]  m1_wstrb,
	output logic                            m1_wready,
	output logic                            m1_bvalid,
	output axi_mem_pkg::resp_t              m1_bresp,
	input  logic                            m1_bready
);

	axi_lite_if if_m0 ();
	axi_lite_if if_m1 ();
	// arbiter to sram
	axi_lite_if if_mem ();

	// m0 pins into its bundle
	assign if_m0.arvalid = m0_arvalid;
	assign if_m0.araddr = m0_araddr;
	assign if_m0.rready = m0_rready;
	assign if_m0.awvalid = m0_awvalid;
	assign if_m0.awaddr = m0_awaddr;
	assign if_m0.wvalid = m0_wvalid;
	assign if_m0.wdata = m0_wdata;
	assign if_m0.wstrb = m0_wstrb;
	assign if_m0.bready = m0_bready;
	assign m0_arready = if_m0.arready;
	assign m0_rvalid = if_m0.rvalid;
	assign m0_rdata = if_m0.rdata;
	assign m0_rresp = if_m0.rresp;
	assign m0_awready = if_m0.awready;
	assign m0_wready = if_m0.wready;
	assign m0_bvalid = if_m0.bvalid;
	assign m0_bresp = if_m0.bresp;

	// m1 pins into its bundle
	assign if_m1.arvalid = m1_arvalid;
	assign if_m1.araddr = m1_araddr;
	assign if_m1.rready = m1_rready;
	assign if_m1.awvalid = m1_awvalid;
	assign if_m1.awaddr = m1_awaddr;
	assign if_m1.wvalid = m1_wvalid;
	assign if_m1.wdata = m1_wdata;
	assign if_m1.wstrb = m1_wstrb;
	assign if_m1.bready = m1_bready;
	assign m1_arready = if_m1.arready;
	assign m1_rvalid = if_m1.rvalid;
	assign m1_rdata = if_m1.rdata;
	assign m1_rresp = if_m1.rresp;
	assign m1_awready = if_m1.awready;
	assign m1_wready = if_m1.wready;
	assign m1_bvalid = if_m1.bvalid;
	assign m1_bresp = if_m1.bresp;

	axi_rr_arbiter u_arb (
		.clk (clk),
		.rst (rst),
		.m0  (if_m0.slave),
		.m1  (if_m1.slave),
		.mem (if_mem.master)
	);

	axi_sram #(
		.mem_words (mem_words)
	) u_sram (
		.clk (clk),
		.rst (rst),
		.s   (if_mem.slave)
	);

endmodule

// ==== design/axi_rr_arbiter.sv ====
`timescale 1ns/1ps

module axi_rr_arbiter (
	input logic        clk,
	input logic        rst,
	axi_lite_if.slave  m0,
	axi_lite_if.slave  m1,
	axi_lite_if.master mem
);
	import axi_mem_pkg::*;

	// per channel owner, kept after release as the last winner
	logic   rd_busy;
	grant_t rd_grant;
	logic   wr_busy;
	grant_t wr_grant;

	// granted and busy, per master and channel
	logic rd_sel0;
	logic rd_sel1;
	logic wr_sel0;
	logic wr_sel1;

	// round robin pick
	// on a tie the loser of the last round wins
	function automatic grant_t pick(input logic req0, input logic req1, input grant_t last);
		if (req0 && req1) begin
			return (last == grant_m0) ? grant_m1 : grant_m0;
		end
		return req1 ? grant_m1 : grant_m0;
	endfunction

	// read channel owner
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_busy <= 1'b0;
			rd_grant <= grant_m1;
		end else if (!rd_busy) begin
			if (m0.arvalid || m1.arvalid) begin
				rd_busy <= 1'b1;
				rd_grant <= pick(m0.arvalid, m1.arvalid, rd_grant);
			end
		end else if (mem.rvalid && mem.rready) begin
			// released on the r transfer
			rd_busy <= 1'b0;
		end
	end

	// write channel owner
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_busy <= 1'b0;
			wr_grant <= grant_m1;
		end else if (!wr_busy) begin
			if (m0.awvalid || m1.awvalid) begin
				wr_busy <= 1'b1;
				wr_grant <= pick(m0.awvalid, m1.awvalid, wr_grant);
			end
		end else if (mem.bvalid && mem.bready) begin
			wr_busy <= 1'b0;
		end
	end

	assign rd_sel0 = rd_busy && (rd_grant == grant_m0);
	assign rd_sel1 = rd_busy && (rd_grant == grant_m1);
	assign wr_sel0 = wr_busy && (wr_grant == grant_m0);
	assign wr_sel1 = wr_busy && (wr_grant == grant_m1);

	// read requests toward the sram
	assign mem.arvalid = (rd_sel0 && m0.arvalid) || (rd_sel1 && m1.arvalid);
	assign mem.araddr = rd_sel1 ? m1.araddr : m0.araddr;
	assign mem.rready = (rd_sel0 && m0.rready) || (rd_sel1 && m1.rready);

	// read responses, owner only
	assign m0.arready = rd_sel0 && mem.arready;
	assign m0.rvalid = rd_sel0 && mem.rvalid;
	assign m0.rdata = rd_sel0 ? mem.rdata : '0;
	assign m0.rresp = rd_sel0 ? mem.rresp : resp_okay;

	assign m1.arready = rd_sel1 && mem.arready;
	assign m1.rvalid = rd_sel1 && mem.rvalid;
	assign m1.rdata = rd_sel1 ? mem.rdata : '0;
	assign m1.rresp = rd_sel1 ? mem.rresp : resp_okay;

	// write requests, aw and w travel together
	assign mem.awvalid = (wr_sel0 && m0.awvalid) || (wr_sel1 && m1.awvalid);
	assign mem.awaddr = wr_sel1 ? m1.awaddr : m0.awaddr;
	assign mem.wvalid = (wr_sel0 && m0.wvalid) || (wr_sel1 && m1.wvalid);
	assign mem.wdata = wr_sel1 ? m1.wdata : m0.wdata;
	assign mem.wstrb = wr_sel1 ? m1.wstrb : m0.wstrb;
	assign mem.bready = (wr_sel0 && m0.bready) || (wr_sel1 && m1.bready);

	// write responses, owner only
	assign m0.awready = wr_sel0 && mem.awready;
	assign m0.wready = wr_sel0 && mem.wready;
	assign m0.bvalid = wr_sel0 && mem.bvalid;
	assign m0.bresp = wr_sel0 ? mem.bresp : resp_okay;

	assign m1.awready = wr_sel1 && mem.awready;
	assign m1.wready = wr_sel1 && mem.wready;
	assign m1.bvalid = wr_sel1 && mem.bvalid;
	assign m1.bresp = wr_sel1 ? mem.bresp : resp_okay;

	// idle channel means nothing in flight on either side of the arbiter
	a_rd_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		!rd_busy |-> !mem.arvalid && !mem.rvalid);
	a_wr_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		!wr_busy |-> !mem.awvalid && !mem.wvalid && !mem.bvalid);

	// owner fixed for the whole transaction
	a_rd_grant_hold: assert property (@(posedge clk) disable iff (rst)
		rd_busy |=> $stable(rd_grant));
	a_wr_grant_hold: assert property (@(posedge clk) disable iff (rst)
		wr_busy |=> $stable(wr_grant));

endmodule

// ==== design/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram #(
	parameter int mem_words = 1024
) (
	input logic       clk,
	input logic       rst,
	axi_lite_if.slave s
);
	import axi_mem_pkg::*;

	// word index width after dropping the byte offset
	localparam int idx_w = addr_w - off_w;
	// array address width, at least one bit
	localparam int mem_aw = (mem_words > 1) ? $clog2(mem_words) : 1;

	typedef enum logic [1:0] {
		st_idle = 2'b00,
		st_resp = 2'b01
	} state_t;

	// backing store, no preload
	logic [data_w-1:0] mem [mem_words];

	state_t            rd_state;
	state_t            rd_next;
	logic [idx_w-1:0]  ar_idx;
	logic              ar_ok;
	logic              ar_fire;
	logic              r_fire;
	logic [data_w-1:0] rdata_q;
	resp_t             rresp_q;

	state_t            wr_state;
	state_t            wr_next;
	logic [idx_w-1:0]  aw_idx;
	logic              aw_ok;
	logic              wr_fire;
	logic              b_fire;
	resp_t             bresp_q;

	// read side
	assign ar_idx = s.araddr[addr_w-1:off_w];
	assign ar_ok = 32'(ar_idx) < 32'(mem_words);

	// always ready while no response is pending
	assign s.arready = (rd_state == st_idle);
	assign ar_fire = s.arvalid && s.arready;
	assign s.rvalid = (rd_state == st_resp);
	assign r_fire = s.rvalid && s.rready;
	assign s.rdata = rdata_q;
	assign s.rresp = rresp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= st_idle;
		end else begin
			rd_state <= rd_next;
		end
	end

	always_comb begin
		case (rd_state)
			st_idle: rd_next = ar_fire ? st_resp : st_idle;
			// hold the beat until the master takes it
			st_resp: rd_next = r_fire ? st_idle : st_resp;
			// spare code, recover to idle
			default: rd_next = st_idle;
		endcase
	end

	// data captured at the ar transfer, shown one cycle later
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata_q <= ar_ok ? mem[ar_idx[mem_aw-1:0]] : '0;
			rresp_q <= ar_ok ? resp_okay : resp_slverr;
		end
	end

	// write side
	assign aw_idx = s.awaddr[addr_w-1:off_w];
	assign aw_ok = 32'(aw_idx) < 32'(mem_words);

	// aw and w accepted only as a pair
	assign s.awready = (wr_state == st_idle) && s.awvalid && s.wvalid;
	assign s.wready = s.awready;
	assign wr_fire = s.awvalid && s.awready;
	assign s.bvalid = (wr_state == st_resp);
	assign b_fire = s.bvalid && s.bready;
	assign s.bresp = bresp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= st_idle;
		end else begin
			wr_state <= wr_next;
		end
	end

	always_comb begin
		case (wr_state)
			st_idle: wr_next = wr_fire ? st_resp : st_idle;
			st_resp: wr_next = b_fire ? st_idle : st_resp;
			default: wr_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp_q <= aw_ok ? resp_okay : resp_slverr;
		end
	end

	// byte lane merge, out of range writes dropped
	always_ff @(posedge clk) begin
		if (wr_fire && aw_ok) begin
			for (int i = 0; i < strb_w; i++) begin
				if (s.wstrb[i]) begin
					mem[aw_idx[mem_aw-1:0]][8*i +: 8] <= s.wdata[8*i +: 8];
				end
			end
		end
	end

	// responses hold under back-pressure
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		s.rvalid && !s.rready |=> s.rvalid && $stable(s.rdata));
	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		s.bvalid && !s.bready |=> s.bvalid);

	// only okay or slverr ever leave this slave
	a_resp_codes: assert property (@(posedge clk) disable iff (rst)
		(s.rvalid |-> s.rresp inside {resp_okay, resp_slverr}) and
		(s.bvalid |-> s.bresp inside {resp_okay, resp_slverr}));

endmodule

// ==== design/axi_lite_if.sv ====
`timescale 1ns/1ps

interface axi_lite_if;
	import axi_mem_pkg::*;

	// read address channel
	logic              arvalid;
	logic [addr_w-1:0] araddr;
	logic              arready;

	// read data channel
	logic              rvalid;
	logic [data_w-1:0] rdata;
	resp_t             rresp;
	logic              rready;

	// write address channel
	logic              awvalid;
	logic [addr_w-1:0] awaddr;
	logic              awready;

	// write data channel, presented together with aw
	logic              wvalid;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] wstrb;
	logic              wready;

	// write response channel
	logic              bvalid;
	resp_t             bresp;
	logic              bready;

	// requester side
	modport master (
		output arvalid, araddr, rready,
		output awvalid, awaddr, wvalid, wdata, wstrb, bready,
		input  arready, rvalid, rdata, rresp,
		input  awready, wready, bvalid, bresp
	);

	// responder side
	modport slave (
		input  arvalid, araddr, rready,
		input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
		output arready, rvalid, rdata, rresp,
		output awready, wready, bvalid, bresp
	);

endinterface

// ==== design/axi_mem_pkg.sv ====
package axi_mem_pkg;

	// byte address width on every port
	localparam int addr_w = 32;

	// one memory word per beat
	localparam int data_w = 64;

	// one strobe bit per data byte
	localparam int strb_w = data_w / 8;

	// byte offset bits inside a word, dropped to form the word index
	localparam int off_w = $clog2(strb_w);

	// axi response codes
	// exokay and decerr are never produced here
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} resp_t;

	// owner of a channel inside the arbiter
	// also serves as the last-winner pointer once the channel goes idle
	typedef enum logic {
		grant_m0 = 1'b0,
		grant_m1 = 1'b1
	} grant_t;

endpackage
